//--- common/pipe_cfg.svh
`ifndef PIPE_CFG_SVH
`define PIPE_CFG_SVH

// Datapath and pc width
`define PIPE_XLEN 32

// Architectural register count
// Entry 0 is the hard-wired zero register
`define PIPE_NREGS 32

// Immediate field width in I-type encodings
`define PIPE_IMM_W 16

`endif

//--- common/pipe_pkg.sv
`default_nettype none

`include "pipe_cfg.svh"

package pipe_pkg;

	// Register address width follows the register count
	localparam int REG_AW = $clog2(`PIPE_NREGS);

	// ALU operations
	// SLT and SLTU share the compare path
	// alu_sign picks the flavour
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLT  = 4'd5,
		ALU_SLTU = 4'd6,
		ALU_LUI  = 4'd7
	} alu_op_e;

	////////////////////////////////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////////////////////////////////

	// Decode to execute
	typedef struct packed {
		alu_op_e                aluop;
		logic [`PIPE_XLEN-1:0]  rega;
		logic [`PIPE_XLEN-1:0]  regb;
		logic [`PIPE_IMM_W-1:0] imme;
		logic [`PIPE_XLEN-1:0]  pc;
		// Sign-extend the immediate
		logic                   sign;
		// B operand comes from the immediate
		logic                   srcb;
		// Signed comparison for set-less-than
		logic                   alu_sign;
		logic [REG_AW-1:0]      wb_dreg;
		// Low for bubbles
		logic                   wb_we;
	} id_exe_t;

	// Execute to writeback
	typedef struct packed {
		logic [`PIPE_XLEN-1:0] pc;
		logic [`PIPE_XLEN-1:0] result;
		logic [REG_AW-1:0]     wb_dreg;
		logic                  wb_we;
	} exe_wb_t;

endpackage

`default_nettype wire

//--- src/pipe_reg.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     en,
	input  wire payload_t d,
	output payload_t      q
);

	// Holds while stalled and clears to a bubble on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			q <= '0;
		end else if (en) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

//--- decode/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cfg.svh"

module reg_file (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire logic                        we,
	input  wire logic [pipe_pkg::REG_AW-1:0] waddr,
	input  wire logic [`PIPE_XLEN-1:0]       wdata,
	input  wire logic [pipe_pkg::REG_AW-1:0] ra_addr,
	input  wire logic [pipe_pkg::REG_AW-1:0] rb_addr,
	output logic      [`PIPE_XLEN-1:0]       ra_data,
	output logic      [`PIPE_XLEN-1:0]       rb_data
);

	logic [`PIPE_XLEN-1:0] regs [`PIPE_NREGS];

	// Synchronous write
	// Register 0 is never stored and keeps its reset value of zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `PIPE_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// Asynchronous reads
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];

endmodule

`default_nettype wire

//--- decode/id_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cfg.svh"

module id_decoder (
	input  wire logic                          instr_valid,
	input  wire logic [`PIPE_XLEN-1:0]         instr,
	input  wire logic [`PIPE_XLEN-1:0]         pc,
	input  wire logic [`PIPE_XLEN-1:0]         ra_data,
	input  wire logic [`PIPE_XLEN-1:0]         rb_data,
	input  wire pipe_pkg::exe_wb_t             exe_fwd,
	input  wire pipe_pkg::exe_wb_t             wb_fwd,
	output logic      [pipe_pkg::REG_AW-1:0]   ra_addr,
	output logic      [pipe_pkg::REG_AW-1:0]   rb_addr,
	output pipe_pkg::id_exe_t                  id_out
);

	logic [5:0]                  opcode;
	logic [5:0]                  funct;
	logic [pipe_pkg::REG_AW-1:0] rs;
	logic [pipe_pkg::REG_AW-1:0] rt;
	logic [pipe_pkg::REG_AW-1:0] rd;
	pipe_pkg::alu_op_e           aluop;
	logic                        srcb;
	logic                        sign;
	logic                        alu_sign;
	logic                        r_type;
	logic                        legal;

	// Youngest producer wins
	// Register 0 is always zero
	function automatic logic [`PIPE_XLEN-1:0] fwd_operand(
		input logic [pipe_pkg::REG_AW-1:0] src,
		input logic [`PIPE_XLEN-1:0]       rf_data,
		input pipe_pkg::exe_wb_t           exe,
		input pipe_pkg::exe_wb_t           wb
	);
		logic [`PIPE_XLEN-1:0] val;
		if (src == '0)
			val = '0;
		else if (exe.wb_we && exe.wb_dreg == src)
			val = exe.result;
		else if (wb.wb_we && wb.wb_dreg == src)
			val = wb.result;
		else
			val = rf_data;
		return val;
	endfunction

	assign opcode  = instr[31:26];
	assign rs      = instr[25:21];
	assign rt      = instr[20:16];
	assign rd      = instr[15:11];
	assign funct   = instr[5:0];
	assign ra_addr = rs;
	assign rb_addr = rt;

	////////////////////////////////////////////////////////////////////
	// Control decode
	////////////////////////////////////////////////////////////////////

	always_comb begin
		aluop    = pipe_pkg::ALU_ADD;
		srcb     = 1'b0;
		sign     = 1'b0;
		alu_sign = 1'b0;
		r_type   = 1'b0;
		legal    = 1'b1;
		case (opcode)
			// SPECIAL group with the operation in funct
			6'h00: begin
				r_type = 1'b1;
				case (funct)
					6'h21: aluop = pipe_pkg::ALU_ADD;
					6'h23: aluop = pipe_pkg::ALU_SUB;
					6'h24: aluop = pipe_pkg::ALU_AND;
					6'h25: aluop = pipe_pkg::ALU_OR;
					6'h26: aluop = pipe_pkg::ALU_XOR;
					6'h2a: begin
						aluop    = pipe_pkg::ALU_SLT;
						alu_sign = 1'b1;
					end
					6'h2b: aluop = pipe_pkg::ALU_SLTU;
					default: legal = 1'b0;
				endcase
			end
			// addiu
			6'h09: begin
				srcb = 1'b1;
				sign = 1'b1;
			end
			// slti
			6'h0a: begin
				aluop    = pipe_pkg::ALU_SLT;
				srcb     = 1'b1;
				sign     = 1'b1;
				alu_sign = 1'b1;
			end
			// sltiu sign-extends but compares unsigned
			6'h0b: begin
				aluop = pipe_pkg::ALU_SLTU;
				srcb  = 1'b1;
				sign  = 1'b1;
			end
			// Logic immediates are zero-extended
			6'h0c: begin
				aluop = pipe_pkg::ALU_AND;
				srcb  = 1'b1;
			end
			6'h0d: begin
				aluop = pipe_pkg::ALU_OR;
				srcb  = 1'b1;
			end
			6'h0e: begin
				aluop = pipe_pkg::ALU_XOR;
				srcb  = 1'b1;
			end
			6'h0f: begin
				aluop = pipe_pkg::ALU_LUI;
				srcb  = 1'b1;
			end
			default: legal = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////////////
	// Payload assembly
	////////////////////////////////////////////////////////////////////

	always_comb begin
		id_out          = '0;
		id_out.aluop    = aluop;
		id_out.rega     = fwd_operand(rs, ra_data, exe_fwd, wb_fwd);
		id_out.regb     = fwd_operand(rt, rb_data, exe_fwd, wb_fwd);
		id_out.imme     = instr[`PIPE_IMM_W-1:0];
		id_out.pc       = pc;
		id_out.sign     = sign;
		id_out.srcb     = srcb;
		id_out.alu_sign = alu_sign;
		id_out.wb_dreg  = r_type ? rd : rt;
		// Unsupported encodings travel as bubbles
		id_out.wb_we    = instr_valid & legal;
	end

endmodule

`default_nettype wire

//--- src/exe_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cfg.svh"

module exe_alu (
	input  wire pipe_pkg::id_exe_t id_in,
	output pipe_pkg::exe_wb_t      exe_out
);

	localparam int EXT_W = `PIPE_XLEN - `PIPE_IMM_W;

	logic [`PIPE_XLEN-1:0] imm_ext;
	logic [`PIPE_XLEN-1:0] op_b;
	logic [`PIPE_XLEN-1:0] result;
	logic                  less;

	// Immediate extension and B select
	assign imm_ext = id_in.sign ? {{EXT_W{id_in.imme[`PIPE_IMM_W-1]}}, id_in.imme}
	                            : {{EXT_W{1'b0}}, id_in.imme};
	assign op_b    = id_in.srcb ? imm_ext : id_in.regb;

	// One comparator for both set-less-than flavours
	assign less = id_in.alu_sign ? ($signed(id_in.rega) < $signed(op_b))
	                             : (id_in.rega < op_b);

	always_comb begin
		case (id_in.aluop)
			pipe_pkg::ALU_ADD:  result = id_in.rega + op_b;
			pipe_pkg::ALU_SUB:  result = id_in.rega - op_b;
			pipe_pkg::ALU_AND:  result = id_in.rega & op_b;
			pipe_pkg::ALU_OR:   result = id_in.rega | op_b;
			pipe_pkg::ALU_XOR:  result = id_in.rega ^ op_b;
			pipe_pkg::ALU_SLT,
			pipe_pkg::ALU_SLTU: result = {{(`PIPE_XLEN-1){1'b0}}, less};
			// Immediate into the upper half
			pipe_pkg::ALU_LUI:  result = {id_in.imme, {EXT_W{1'b0}}};
			default:            result = '0;
		endcase
	end

	assign exe_out = '{
		pc:      id_in.pc,
		result:  result,
		wb_dreg: id_in.wb_dreg,
		wb_we:   id_in.wb_we
	};

endmodule

`default_nettype wire

//--- src/core_slice.sv
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cfg.svh"

module core_slice (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire logic                        en,
	input  wire logic                        instr_valid,
	input  wire logic [`PIPE_XLEN-1:0]       instr,
	input  wire logic [`PIPE_XLEN-1:0]       pc,
	output logic                             wb_valid,
	output logic      [`PIPE_XLEN-1:0]       wb_pc,
	output logic      [pipe_pkg::REG_AW-1:0] wb_dreg,
	output logic      [`PIPE_XLEN-1:0]       wb_data
);

	logic [pipe_pkg::REG_AW-1:0] ra_addr;
	logic [pipe_pkg::REG_AW-1:0] rb_addr;
	logic [`PIPE_XLEN-1:0]       ra_data;
	logic [`PIPE_XLEN-1:0]       rb_data;
	pipe_pkg::id_exe_t           id_out;
	pipe_pkg::id_exe_t           id_q;
	// ALU output doubles as the execute-stage forward source
	pipe_pkg::exe_wb_t           exe_fwd;
	// EXE/WB register doubles as the writeback forward source
	pipe_pkg::exe_wb_t           wb_fwd;

	//////////////////////////////////////////////////////////////////////
	// Decode and register read
	//////////////////////////////////////////////////////////////////////

	id_decoder u_id_decoder (
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.ra_data     (ra_data),
		.rb_data     (rb_data),
		.exe_fwd     (exe_fwd),
		.wb_fwd      (wb_fwd),
		.ra_addr     (ra_addr),
		.rb_addr     (rb_addr),
		.id_out      (id_out)
	);

	// Write port fires with the writeback report
	reg_file u_reg_file (
		.clk     (clk),
		.rst     (rst),
		.we      (wb_valid),
		.waddr   (wb_fwd.wb_dreg),
		.wdata   (wb_fwd.result),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.ra_data (ra_data),
		.rb_data (rb_data)
	);

	//////////////////////////////////////////////////////////////////////
	// Execute and writeback
	//////////////////////////////////////////////////////////////////////

	pipe_reg #(.payload_t(pipe_pkg::id_exe_t)) u_id_exe (
		.clk (clk),
		.rst (rst),
		.en  (en),
		.d   (id_out),
		.q   (id_q)
	);

	exe_alu u_exe_alu (
		.id_in   (id_q),
		.exe_out (exe_fwd)
	);

	pipe_reg #(.payload_t(pipe_pkg::exe_wb_t)) u_exe_wb (
		.clk (clk),
		.rst (rst),
		.en  (en),
		.d   (exe_fwd),
		.q   (wb_fwd)
	);

	// Qualified by en so a stalled instruction reports once
	assign wb_valid = wb_fwd.wb_we & en;
	assign wb_pc    = wb_fwd.pc;
	assign wb_dreg  = wb_fwd.wb_dreg;
	assign wb_data  = wb_fwd.result;

endmodule

`default_nettype wire

//--- sim/core_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cfg.svh"

module core_checker (
	input wire logic                        clk,
	input wire logic                        rst,
	input wire logic                        en,
	input wire logic                        wb_valid,
	input wire logic [`PIPE_XLEN-1:0]       wb_pc,
	input wire logic [pipe_pkg::REG_AW-1:0] wb_dreg,
	input wire logic [`PIPE_XLEN-1:0]       wb_data,
	input wire logic [pipe_pkg::REG_AW-1:0] ra_addr,
	input wire logic [pipe_pkg::REG_AW-1:0] rb_addr,
	input wire pipe_pkg::id_exe_t           id_out
);

	// Count of failed assertions
	int fail_count = 0;

	// Both pipeline registers clear to bubbles
	a_quiet_after_reset: assert property (@(posedge clk) rst |=> !wb_valid)
		else begin
			fail_count++;
			$error("wb_valid high in the cycle after reset");
		end

	// A stalled writeback stage keeps its instruction for the later report
	a_hold_in_stall: assert property (@(posedge clk) disable iff (rst)
		!en |=> $stable({wb_pc, wb_dreg, wb_data}))
		else begin
			fail_count++;
			$error("writeback fields changed while en was low");
		end

	// Decoded operands stay zero even with a register 0 writer in flight
	a_zero_reg_a: assert property (@(posedge clk) disable iff (rst)
		(ra_addr == '0) |-> (id_out.rega == '0))
		else begin
			fail_count++;
			$error("register 0 read nonzero on operand A");
		end

	a_zero_reg_b: assert property (@(posedge clk) disable iff (rst)
		(rb_addr == '0) |-> (id_out.regb == '0))
		else begin
			fail_count++;
			$error("register 0 read nonzero on operand B");
		end

endmodule

bind core_slice core_checker u_checker (
	.clk      (clk),
	.rst      (rst),
	.en       (en),
	.wb_valid (wb_valid),
	.wb_pc    (wb_pc),
	.wb_dreg  (wb_dreg),
	.wb_data  (wb_data),
	.ra_addr  (ra_addr),
	.rb_addr  (rb_addr),
	.id_out   (id_out)
);

`default_nettype wire

//--- sim/core_monitor.sv
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cfg.svh"

module core_monitor (
	input wire logic                        clk,
	input wire logic                        rst,
	input wire logic                        en,
	input wire logic                        instr_valid,
	input wire logic [`PIPE_XLEN-1:0]       instr,
	input wire logic [`PIPE_XLEN-1:0]       pc,
	input wire logic                        wb_valid,
	input wire logic [`PIPE_XLEN-1:0]       wb_pc,
	input wire logic [pipe_pkg::REG_AW-1:0] wb_dreg,
	input wire logic [`PIPE_XLEN-1:0]       wb_data
);

	// One expected writeback stamped with the enabled-cycle count at capture
	typedef struct packed {
		logic [`PIPE_XLEN-1:0]       pc;
		logic [pipe_pkg::REG_AW-1:0] dreg;
		logic [`PIPE_XLEN-1:0]       data;
		logic [31:0]                 stamp;
	} exp_t;

	logic [`PIPE_XLEN-1:0] model_regs [`PIPE_NREGS];
	exp_t                  expected [$];
	logic [31:0]           en_ticks = '0;
	int                    err_count = 0;
	int                    report_count = 0;
	int                    pending = 0;

	//////////////////////////////////////////////////////////////////////
	// Reference model of the supported MIPS subset
	//////////////////////////////////////////////////////////////////////

	function automatic logic ref_exec(
		input  logic [`PIPE_XLEN-1:0]       ins,
		input  logic [`PIPE_XLEN-1:0]       a,
		input  logic [`PIPE_XLEN-1:0]       b,
		output logic [pipe_pkg::REG_AW-1:0] dest,
		output logic [`PIPE_XLEN-1:0]       res
	);
		logic [`PIPE_XLEN-1:0] sext;
		logic [`PIPE_XLEN-1:0] zext;
		logic                  ok;
		sext = {{16{ins[15]}}, ins[15:0]};
		zext = {16'h0000, ins[15:0]};
		ok   = 1'b1;
		dest = ins[20:16];
		res  = '0;
		case (ins[31:26])
			6'h00: begin
				dest = ins[15:11];
				case (ins[5:0])
					6'h21: res = a + b;
					6'h23: res = a - b;
					6'h24: res = a & b;
					6'h25: res = a | b;
					6'h26: res = a ^ b;
					6'h2a: res = {31'b0, $signed(a) < $signed(b)};
					6'h2b: res = {31'b0, a < b};
					default: ok = 1'b0;
				endcase
			end
			6'h09: res = a + sext;
			6'h0a: res = {31'b0, $signed(a) < $signed(sext)};
			6'h0b: res = {31'b0, a < sext};
			6'h0c: res = a & zext;
			6'h0d: res = a | zext;
			6'h0e: res = a ^ zext;
			6'h0f: res = {ins[15:0], 16'h0000};
			default: ok = 1'b0;
		endcase
		return ok;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Sampling at the falling edge where ports are settled
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		exp_t                        head;
		logic [pipe_pkg::REG_AW-1:0] dest;
		logic [`PIPE_XLEN-1:0]       res;
		logic                        ok;
		if (rst) begin
			model_regs = '{default: '0};
			expected.delete();
			en_ticks = '0;
		end else begin
			if (en)
				en_ticks = en_ticks + 32'd1;
			// Older instruction retires before the new one is taken
			if (wb_valid) begin
				report_count++;
				if (expected.size() == 0) begin
					err_count++;
					$display("unexpected writeback at %0t ns: pc %h reported with nothing pending",
						$time, wb_pc);
				end else begin
					head = expected.pop_front();
					if (wb_pc !== head.pc || wb_dreg !== head.dreg || wb_data !== head.data) begin
						err_count++;
						$display("error at %0t ns: got pc %h r%0d=%h, expected pc %h r%0d=%h",
							$time, wb_pc, wb_dreg, wb_data, head.pc, head.dreg, head.data);
					end
					if (en_ticks - head.stamp != 32'd2) begin
						err_count++;
						$display("error at %0t ns: pc %h took %0d enabled cycles, expected 2",
							$time, head.pc, en_ticks - head.stamp);
					end
				end
			end
			if (en && instr_valid) begin
				ok = ref_exec(instr, model_regs[instr[25:21]], model_regs[instr[20:16]],
					dest, res);
				if (ok) begin
					if (dest != '0)
						model_regs[dest] = res;
					expected.push_back('{pc: pc, dreg: dest, data: res, stamp: en_ticks});
				end
			end
		end
		pending = expected.size();
	end

endmodule

`default_nettype wire

//--- sim/tb_core_slice.sv
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cfg.svh"

module tb_core_slice;

	// Stimulus mix for one phase
	// Rates are percentages out of 100
	typedef struct packed {
		int unsigned reg_max;
		int unsigned valid_pct;
		int unsigned en_pct;
		int unsigned illegal_pct;
		int unsigned zero_dest_pct;
	} knobs_t;

	localparam logic [6:0][5:0] R_FUNCTS = {6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h2b};
	localparam logic [6:0][5:0] I_OPS    = {6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
	localparam int DRAIN_LIMIT = 50;

	logic                        clk;
	logic                        rst;
	logic                        en;
	logic                        instr_valid;
	logic [`PIPE_XLEN-1:0]       instr;
	logic [`PIPE_XLEN-1:0]       pc;
	logic                        wb_valid;
	logic [`PIPE_XLEN-1:0]       wb_pc;
	logic [pipe_pkg::REG_AW-1:0] wb_dreg;
	logic [`PIPE_XLEN-1:0]       wb_data;
	logic [`PIPE_XLEN-1:0]       next_pc;
	logic                        timed_out;

	core_slice DUT (
		.clk         (clk),
		.rst         (rst),
		.en          (en),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.wb_valid    (wb_valid),
		.wb_pc       (wb_pc),
		.wb_dreg     (wb_dreg),
		.wb_data     (wb_data)
	);

	core_monitor u_monitor (
		.clk         (clk),
		.rst         (rst),
		.en          (en),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.wb_valid    (wb_valid),
		.wb_pc       (wb_pc),
		.wb_dreg     (wb_dreg),
		.wb_data     (wb_data)
	);

	always #10 clk = ~clk;

	function automatic int total_errors();
		return u_monitor.err_count + DUT.u_checker.fail_count;
	endfunction

	function automatic logic [`PIPE_XLEN-1:0] rand_instr(input knobs_t k);
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		logic [3:0]  sel;
		rs  = 5'($urandom_range(k.reg_max, 0));
		rt  = 5'($urandom_range(k.reg_max, 0));
		rd  = 5'($urandom_range(k.reg_max, 0));
		imm = 16'($urandom);
		sel = 4'($urandom_range(13, 0));
		if ($urandom_range(99, 0) < k.zero_dest_pct) begin
			rd = '0;
			rt = '0;
		end
		// lw and sll are outside the subset
		if ($urandom_range(99, 0) < k.illegal_pct)
			return ($urandom_range(1, 0) != 0) ? {6'h23, rs, rt, imm}
			                                   : {6'h00, rs, rt, rd, 5'd0, 6'h00};
		if (sel < 4'd7)
			return {6'h00, rs, rt, rd, 5'd0, R_FUNCTS[sel[2:0]]};
		return {I_OPS[3'(sel - 4'd7)], rs, rt, imm};
	endfunction

	task automatic advance_pc();
		pc      = next_pc;
		next_pc = next_pc + 32'd4;
	endtask

	// Let every accepted instruction retire
	task automatic drain();
		int cycles;
		cycles = 0;
		@(posedge clk);
		#2;
		en          = 1'b1;
		instr_valid = 1'b0;
		while (u_monitor.pending != 0 && cycles < DRAIN_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (u_monitor.pending != 0) begin
			timed_out = 1'b1;
			$display("timeout: %0d accepted instructions were never reported after %0d cycles",
				u_monitor.pending, cycles);
		end
	endtask

	task automatic report_test(input string name, input int errs_before, input int reps_before);
		$display("test %s: %0d reports, %0d errors", name,
			u_monitor.report_count - reps_before, total_errors() - errs_before);
	endtask

	// Every result is zero while all registers still hold zero
	task automatic read_sweep();
		int errs_before;
		int reps_before;
		errs_before = total_errors();
		reps_before = u_monitor.report_count;
		for (int r = 0; r < `PIPE_NREGS; r++) begin
			@(posedge clk);
			#2;
			en          = 1'b1;
			instr_valid = 1'b1;
			instr       = {6'h00, 5'(r), 5'(31 - r), 5'd0, 5'd0, 6'h25};
			advance_pc();
		end
		drain();
		report_test("reset_zero", errs_before, reps_before);
	endtask

	task automatic run_phase(input string name, input int count, input knobs_t k);
		int errs_before;
		int reps_before;
		if (timed_out)
			return;
		errs_before = total_errors();
		reps_before = u_monitor.report_count;
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			#2;
			en          = ($urandom_range(99, 0) < k.en_pct);
			instr_valid = ($urandom_range(99, 0) < k.valid_pct);
			instr       = rand_instr(k);
			advance_pc();
		end
		drain();
		report_test(name, errs_before, reps_before);
	endtask

	initial begin
		clk         = 1'b0;
		rst         = 1'b1;
		en          = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		pc          = '0;
		next_pc     = 32'h0000_1000;
		timed_out   = 1'b0;
		void'($urandom(32'h7b2b));
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;

		read_sweep();
		run_phase("alu_ops", 400, '{7, 90, 100, 0, 5});
		run_phase("dependent", 300, '{3, 100, 100, 0, 0});
		run_phase("zero_bubbles", 300, '{7, 60, 100, 25, 30});
		run_phase("stall", 400, '{5, 90, 55, 5, 5});
		run_phase("full_rate", 300, '{7, 100, 100, 0, 0});

		$display("reports %0d, errors %0d, unreported %0d",
			u_monitor.report_count, total_errors(), u_monitor.pending);
		if (!timed_out && total_errors() == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
common/pipe_pkg.sv
src/pipe_reg.sv
decode/reg_file.sv
decode/id_decoder.sv
src/exe_alu.sv
src/core_slice.sv
sim/core_checker.sv
sim/core_monitor.sv
sim/tb_core_slice.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the core slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_core_slice -f tb.f -Mdir obj_dir; then
	echo "build failed"
	exit 1
fi

# Raise the error limit so failed assertions do not end the run early
out=$(./obj_dir/Vtb_core_slice +verilator+error+limit+1000)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qF '** PASS **'; then
	exit 0
fi
exit 1
